//--- hw/display_pkg.sv
package display_pkg;

	// one bit per colour, r is the msb and b sits at bit 0
	typedef struct packed {
		logic r;
		logic g;
		logic b;
	} pixel_t;

	// scanning runs while enable is set
	typedef struct packed {
		logic enable;
	} ctrl_t;

	localparam int AXIL_ADDR_W = 12;
	localparam int AXIL_DATA_W = 32;

	// control register byte address, pixels live below it
	localparam logic [AXIL_ADDR_W-1:0] CTRL_ADDR = 12'h800;

	// master-driven half of the bus
	typedef struct packed {
		logic [AXIL_ADDR_W-1:0] awaddr;
		logic awvalid;
		logic [AXIL_DATA_W-1:0] wdata;
		logic [AXIL_DATA_W/8-1:0] wstrb;
		logic wvalid;
		logic bready;
		logic [AXIL_ADDR_W-1:0] araddr;
		logic arvalid;
		logic rready;
	} axil_req_t;

	// slave-driven half of the bus
	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [AXIL_DATA_W-1:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axil_rsp_t;

endpackage

//--- hw/display_axil_slave.sv
module display_axil_slave #(
	parameter int columns = 32,
	parameter int rows = 16
) (
	input logic clk,
	input logic rst,
	input display_pkg::axil_req_t axil_req,
	output display_pkg::axil_rsp_t axil_rsp,
	output display_pkg::ctrl_t ctrl,
	output logic [$clog2(rows*columns)-1:0] fb_addr,
	output logic fb_we,
	output display_pkg::pixel_t fb_wdata,
	input display_pkg::pixel_t fb_rdata
);
	localparam int addr_w = $clog2(rows*columns);
	localparam int data_w = display_pkg::AXIL_DATA_W;
	localparam int pixels = rows*columns;
	localparam int top = display_pkg::AXIL_ADDR_W - 1;

	typedef enum logic [1:0] {acc_pixel, acc_ctrl, acc_error} access_t;

	// word address decode, anything unmapped answers slverr
	function automatic access_t decode(input logic [top:0] addr);
		if (addr == display_pkg::CTRL_ADDR)
			return acc_ctrl;
		if (addr < display_pkg::CTRL_ADDR && int'(addr[top:2]) < pixels)
			return acc_pixel;
		return acc_error;
	endfunction

	logic aw_hs;
	logic ar_hs;
	logic rd_pend;
	access_t rd_kind;
	access_t wr_kind;
	logic wr_start;
	logic bvalid;
	logic [1:0] bresp;
	logic rvalid;
	logic [1:0] rresp;
	logic [data_w-1:0] rdata;

	assign wr_kind = decode(axil_req.awaddr);
	// aw and w are taken together, never while a response waits
	assign wr_start = axil_req.awvalid && axil_req.wvalid && !aw_hs && !bvalid;

	// host port is shared, a write acceptance owns it in its cycle
	assign fb_addr = aw_hs ? addr_w'(axil_req.awaddr[top:2]) : addr_w'(axil_req.araddr[top:2]);
	assign fb_we = aw_hs && wr_kind == acc_pixel && axil_req.wstrb[0];
	assign fb_wdata = display_pkg::pixel_t'(axil_req.wdata[$bits(display_pkg::pixel_t)-1:0]);

	always_ff @(posedge clk) begin
		if (rst) begin
			aw_hs <= 1'b0;
			ar_hs <= 1'b0;
			rd_pend <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			ctrl <= '0;
		end else begin
			aw_hs <= wr_start;
			// reads wait whenever a write is about to take the port
			ar_hs <= axil_req.arvalid && !ar_hs && !rd_pend && !rvalid && !wr_start;

			// write side, response one cycle after acceptance
			if (aw_hs) begin
				bvalid <= 1'b1;
				if (wr_kind == acc_ctrl)
					ctrl <= display_pkg::ctrl_t'(axil_req.wdata[$bits(display_pkg::ctrl_t)-1:0]);
			end else if (bvalid && axil_req.bready) begin
				bvalid <= 1'b0;
			end

			// read side, memory data shows up the cycle after acceptance
			rd_pend <= ar_hs;
			if (rd_pend)
				rvalid <= 1'b1;
			else if (rvalid && axil_req.rready)
				rvalid <= 1'b0;
		end
	end

	// response payload, held while valid is up
	always_ff @(posedge clk) begin
		if (aw_hs)
			bresp <= (wr_kind == acc_error) ? 2'd2 : 2'd0;
		if (ar_hs)
			rd_kind <= decode(axil_req.araddr);
		if (rd_pend) begin
			case (rd_kind)
				acc_pixel: rdata <= data_w'(fb_rdata);
				acc_ctrl: rdata <= data_w'(ctrl);
				default: rdata <= '0;
			endcase
			rresp <= (rd_kind == acc_error) ? 2'd2 : 2'd0;
		end
	end

	always_comb begin
		axil_rsp.awready = aw_hs;
		axil_rsp.wready = aw_hs;
		axil_rsp.bresp = bresp;
		axil_rsp.bvalid = bvalid;
		axil_rsp.arready = ar_hs;
		axil_rsp.rdata = rdata;
		axil_rsp.rresp = rresp;
		axil_rsp.rvalid = rvalid;
	end
endmodule

//--- hw/display_frame_buffer.sv
module display_frame_buffer #(
	parameter int columns = 32,
	parameter int rows = 16
) (
	input logic clk,
	input logic [$clog2(rows*columns)-1:0] host_addr,
	input logic host_we,
	input display_pkg::pixel_t host_wdata,
	output display_pkg::pixel_t host_rdata,
	input logic scan_re,
	input logic [$clog2(rows*columns)-1:0] scan_addr,
	output display_pkg::pixel_t scan_rdata
);
	localparam int depth = rows*columns;

	// row-major, index is row*columns + column
	display_pkg::pixel_t mem [depth];

	// host port, read returns the old word on a write cycle
	always_ff @(posedge clk) begin
		if (host_we)
			mem[host_addr] <= host_wdata;
		host_rdata <= mem[host_addr];
	end

	// scan port holds its last word until the next read enable
	always_ff @(posedge clk) begin
		if (scan_re)
			scan_rdata <= mem[scan_addr];
	end
endmodule

//--- hw/display_driver_row_loader.sv
module display_driver_row_loader #(
	parameter int columns = 32,
	parameter int pipe_length = 2
) (
	input logic clk,
	input logic rst,
	input logic load,
	output logic complete,
	output logic oclk,
	output logic [$clog2(columns)-1:0] column,
	output logic pipe
);
	localparam int col_w = $clog2(columns);
	localparam int prime_w = $clog2(pipe_length + 1);
	localparam logic [col_w-1:0] last_col = col_w'(columns - 1);
	localparam logic [prime_w-1:0] primed_full = prime_w'(pipe_length);

	// fetch steps done before the first oclk
	logic [prime_w-1:0] primed;
	// oclk pulses already sent for this row
	logic [col_w-1:0] clocked;

	// sequence per row, oclk runs at half the clock rate
	//   prime  pipe high for pipe_length cycles, columns 0 onwards fetched
	//   gap    one cycle with nothing, so rgb settles before the first edge
	//   shift  oclk low then oclk high with pipe, once per column
	//   done   complete for one cycle, counters back at zero
	// rgb moves on the edge that drops oclk, so it is stable at each rise
	always_ff @(posedge clk) begin
		if (rst || !load) begin
			oclk <= 1'b0;
			pipe <= 1'b0;
			complete <= 1'b0;
			primed <= '0;
			clocked <= '0;
			column <= '0;
		end else begin
			complete <= 1'b0;

			// every pipe cycle consumed a fetch, point at the next column
			if (pipe)
				column <= (column == last_col) ? '0 : column + 1'b1;

			if (primed != primed_full) begin
				pipe <= 1'b1;
				primed <= primed + 1'b1;
			end else if (!oclk) begin
				// pipe still high means priming just ended, insert the gap
				oclk <= !pipe;
				pipe <= !pipe;
			end else begin
				oclk <= 1'b0;
				pipe <= 1'b0;
				if (clocked == last_col) begin
					// last column out, restart from scratch next cycle
					complete <= 1'b1;
					clocked <= '0;
					primed <= '0;
					column <= '0;
				end else begin
					clocked <= clocked + 1'b1;
				end
			end
		end
	end
endmodule

//--- hw/display_pixel_pipe.sv
module display_pixel_pipe #(
	parameter int columns = 32,
	parameter int rows = 16,
	parameter int pipe_length = 2
) (
	input logic clk,
	input logic rst,
	input logic pipe,
	input logic [$clog2(columns)-1:0] column,
	input logic [$clog2(rows)-1:0] row,
	output logic scan_re,
	output logic [$clog2(rows*columns)-1:0] scan_addr,
	input display_pkg::pixel_t scan_rdata,
	output display_pkg::pixel_t rgb
);
	localparam int addr_w = $clog2(rows*columns);

	// the memory read register is the first stage
	assign scan_re = pipe;
	assign scan_addr = addr_w'(int'(row) * columns + int'(column));

	generate
		if (pipe_length > 1) begin : g_delay
			// remaining stages, all step together with the memory read
			display_pkg::pixel_t stage [pipe_length-1];

			always_ff @(posedge clk) begin
				if (rst) begin
					for (int i = 0; i < pipe_length - 1; i++)
						stage[i] <= '0;
				end else if (pipe) begin
					stage[0] <= scan_rdata;
					for (int i = 1; i < pipe_length - 1; i++)
						stage[i] <= stage[i-1];
				end
			end

			assign rgb = stage[pipe_length-2];
		end else begin : g_direct
			assign rgb = scan_rdata;
		end
	endgenerate
endmodule

//--- hw/display_scan_controller.sv
module display_scan_controller #(
	parameter int rows = 16,
	parameter int on_cycles = 8
) (
	input logic clk,
	input logic rst,
	input display_pkg::ctrl_t ctrl,
	input logic complete,
	output logic load,
	output logic [$clog2(rows)-1:0] row,
	output logic latch,
	output logic oe,
	output logic [$clog2(rows)-1:0] row_addr
);
	localparam int row_w = $clog2(rows);
	localparam int dwell_w = $clog2(on_cycles + 1);
	localparam logic [row_w-1:0] last_row = row_w'(rows - 1);
	localparam logic [dwell_w-1:0] dwell_full = dwell_w'(on_cycles);

	// panel lit with the latched row
	logic lit;
	// cycles since the last latch, saturates at on_cycles
	logic [dwell_w-1:0] dwell;

	// next row loads only once the shown row has had its time
	assign load = ctrl.enable && dwell == dwell_full;
	// blank on complete and as soon as scanning is switched off
	assign oe = lit && ctrl.enable && !complete;

	always_ff @(posedge clk) begin
		if (rst) begin
			row <= '0;
			row_addr <= '0;
			latch <= 1'b0;
			lit <= 1'b0;
			// start saturated so the first row loads at once
			dwell <= dwell_full;
		end else begin
			latch <= complete;
			if (complete) begin
				// show the row just shifted in, move loading on
				row_addr <= row;
				row <= (row == last_row) ? '0 : row + 1'b1;
				dwell <= '0;
				lit <= 1'b0;
			end else begin
				if (dwell != dwell_full)
					dwell <= dwell + 1'b1;
				// light up the cycle after latch, stay lit until blanked
				lit <= ctrl.enable && (lit || latch);
			end
		end
	end
endmodule

//--- hw/display_top.sv
module display_top #(
	parameter int columns = 32,
	parameter int rows = 16,
	parameter int pipe_length = 2,
	parameter int on_cycles = 8
) (
	input logic clk,
	input logic rst,
	input display_pkg::axil_req_t axil_req,
	output display_pkg::axil_rsp_t axil_rsp,
	output logic oclk,
	output display_pkg::pixel_t rgb,
	output logic latch,
	output logic oe,
	output logic [$clog2(rows)-1:0] row_addr
);
	localparam int addr_w = $clog2(rows*columns);

	display_pkg::ctrl_t ctrl;

	// host port
	logic [addr_w-1:0] fb_addr;
	logic fb_we;
	display_pkg::pixel_t fb_wdata;
	display_pkg::pixel_t fb_rdata;

	// scan port
	logic scan_re;
	logic [addr_w-1:0] scan_addr;
	display_pkg::pixel_t scan_rdata;

	// loader and sequencer handshake
	logic load;
	logic complete;
	logic pipe;
	logic [$clog2(columns)-1:0] column;
	logic [$clog2(rows)-1:0] load_row;

	display_axil_slave #(.columns(columns), .rows(rows)) slave_i (
		.clk(clk), .rst(rst), .axil_req(axil_req), .axil_rsp(axil_rsp), .ctrl(ctrl),
		.fb_addr(fb_addr), .fb_we(fb_we), .fb_wdata(fb_wdata), .fb_rdata(fb_rdata)
	);

	display_frame_buffer #(.columns(columns), .rows(rows)) frame_buffer_i (
		.clk(clk), .host_addr(fb_addr), .host_we(fb_we), .host_wdata(fb_wdata),
		.host_rdata(fb_rdata), .scan_re(scan_re), .scan_addr(scan_addr),
		.scan_rdata(scan_rdata)
	);

	display_driver_row_loader #(.columns(columns), .pipe_length(pipe_length)) loader_i (
		.clk(clk), .rst(rst), .load(load), .complete(complete), .oclk(oclk),
		.column(column), .pipe(pipe)
	);

	display_pixel_pipe #(.columns(columns), .rows(rows), .pipe_length(pipe_length)) pipe_i (
		.clk(clk), .rst(rst), .pipe(pipe), .column(column), .row(load_row),
		.scan_re(scan_re), .scan_addr(scan_addr), .scan_rdata(scan_rdata), .rgb(rgb)
	);

	display_scan_controller #(.rows(rows), .on_cycles(on_cycles)) scan_i (
		.clk(clk), .rst(rst), .ctrl(ctrl), .complete(complete), .load(load),
		.row(load_row), .latch(latch), .oe(oe), .row_addr(row_addr)
	);
endmodule

//--- tb/display_assert.sv
module display_assert (
	input logic clk,
	input logic rst,
	input display_pkg::ctrl_t ctrl,
	input logic complete,
	input logic load,
	input logic latch,
	input logic oe
);
	// failed assertions so far, summed into the testbench error count
	int failures = 0;

	// latch is a one-cycle strobe
	latch_single_a: assert property (@(posedge clk) disable iff (rst) latch |=> !latch)
	else begin
		failures++;
		$error("latch stayed high for more than one cycle");
	end

	// panel must be blanked while the new row is latched
	latch_blank_a: assert property (@(posedge clk) disable iff (rst) latch |-> !oe)
	else begin
		failures++;
		$error("oe high during latch");
	end

	// blanking starts already at complete
	complete_blank_a: assert property (@(posedge clk) disable iff (rst) complete |-> !oe)
	else begin
		failures++;
		$error("oe high during complete");
	end

	// no row loading while scanning is off
	idle_load_a: assert property (@(posedge clk) disable iff (rst) !ctrl.enable |-> !load)
	else begin
		failures++;
		$error("load high with enable clear");
	end
endmodule

bind display_scan_controller display_assert assert_i (
	.clk(clk), .rst(rst), .ctrl(ctrl), .complete(complete), .load(load),
	.latch(latch), .oe(oe)
);

//--- tb/display_tb.sv
module display_tb;
	localparam int columns = 32;
	localparam int rows = 16;
	localparam int pixels = rows * columns;
	// fill and about twenty-five scanned rows take near 5000 cycles, wide margin on top
	localparam int max_cycles = 40000;

	logic clk;
	logic rst;
	display_pkg::axil_req_t axil_req;
	display_pkg::axil_rsp_t axil_rsp;
	logic oclk;
	display_pkg::pixel_t rgb;
	logic latch;
	logic oe;
	logic [$clog2(rows)-1:0] row_addr;

	// expected frame buffer contents
	display_pkg::pixel_t model [pixels];
	// panel shift register, entry 0 holds the first column clocked in
	display_pkg::pixel_t shifted [columns];
	logic [31:0] lcg_state;
	string current_test;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;
	int cycles;
	int oclk_count;
	int latch_count;
	int expected_row;
	// row checks only once the whole buffer is known
	logic scan_check;

	display_top #(.columns(columns), .rows(rows), .pipe_length(2), .on_cycles(8)) dut_i (
		.clk(clk), .rst(rst), .axil_req(axil_req), .axil_rsp(axil_rsp), .oclk(oclk),
		.rgb(rgb), .latch(latch), .oe(oe), .row_addr(row_addr)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: the run did not finish within %0d clock cycles", max_cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic report_error(input string msg);
		$display("CHECK FAILED at time %0t: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	function automatic logic [15:0] lcg_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	function automatic display_pkg::pixel_t random_pixel();
		logic [15:0] r;
		r = lcg_random();
		return r[2:0];
	endfunction

	// panel model, rgb is stable at every oclk rise
	always @(posedge oclk) begin
		for (int i = 0; i < columns - 1; i++)
			shifted[i] = shifted[i+1];
		shifted[columns-1] = rgb;
		oclk_count = oclk_count + 1;
	end

	// at each latch the shifted row must match the row now selected
	always @(negedge clk) begin
		if (latch && scan_check) begin
			if (oclk_count != columns)
				report_error($sformatf("%0d oclk pulses before latch", oclk_count));
			if (int'(row_addr) != expected_row)
				report_error($sformatf("row_addr %0d, expected %0d", row_addr, expected_row));
			for (int c = 0; c < columns; c++)
				if (shifted[c] !== model[int'(row_addr) * columns + c])
					report_error($sformatf("row %0d column %0d is %b, expected %b", row_addr,
						c, shifted[c], model[int'(row_addr) * columns + c]));
			expected_row = (expected_row + 1) % rows;
			latch_count = latch_count + 1;
		end
		if (latch)
			oclk_count = 0;
	end

	task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		@(negedge clk);
		axil_req.awaddr = addr;
		axil_req.awvalid = 1'b1;
		axil_req.wdata = data;
		axil_req.wstrb = strb;
		axil_req.wvalid = 1'b1;
		axil_req.bready = 1'b1;
		// awready seen low-phase means the next rising edge takes the write
		while (!axil_rsp.awready)
			@(negedge clk);
		if (axil_rsp.wready !== 1'b1)
			report_error("wready not raised together with awready");
		@(negedge clk);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		while (!axil_rsp.bvalid)
			@(negedge clk);
		resp = axil_rsp.bresp;
		@(negedge clk);
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(negedge clk);
		axil_req.araddr = addr;
		axil_req.arvalid = 1'b1;
		axil_req.rready = 1'b1;
		while (!axil_rsp.arready)
			@(negedge clk);
		@(negedge clk);
		axil_req.arvalid = 1'b0;
		while (!axil_rsp.rvalid)
			@(negedge clk);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(negedge clk);
		axil_req.rready = 1'b0;
	endtask

	task automatic write_pixel(input int idx, input display_pkg::pixel_t p);
		logic [1:0] resp;
		axil_write(12'(idx * 4), {29'd0, p}, 4'hf, resp);
		if (resp !== 2'd0)
			report_error($sformatf("pixel %0d write answered %0d", idx, resp));
		model[idx] = p;
	endtask

	task automatic check_pixel(input int idx);
		logic [31:0] data;
		logic [1:0] resp;
		axil_read(12'(idx * 4), data, resp);
		if (resp !== 2'd0 || data !== {29'd0, model[idx]})
			report_error($sformatf("pixel %0d read %h resp %0d, expected %h", idx, data, resp,
				{29'd0, model[idx]}));
	endtask

	task automatic check_ctrl(input logic [31:0] expected);
		logic [31:0] data;
		logic [1:0] resp;
		axil_read(display_pkg::CTRL_ADDR, data, resp);
		if (resp !== 2'd0 || data !== expected)
			report_error($sformatf("control read %h, expected %h", data, expected));
	endtask

	task automatic begin_test(input string name);
		current_test = name;
		test_errors = 0;
		tests_run++;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			$display("test %s: passed", current_test);
		end else begin
			$display("test %s: failed with %0d errors", current_test, test_errors);
			tests_failed++;
		end
	endtask

	task automatic test_reset_state();
		begin_test("reset state");
		if (oclk !== 1'b0 || latch !== 1'b0 || oe !== 1'b0)
			report_error("panel controls not low after reset");
		if (row_addr !== '0)
			report_error($sformatf("row_addr %0d after reset", row_addr));
		if (axil_rsp.bvalid !== 1'b0 || axil_rsp.rvalid !== 1'b0)
			report_error("bus response valid after reset");
		end_test();
	endtask

	task automatic test_register_access();
		int written [$];
		int idx;
		logic [1:0] resp;
		logic [31:0] data;
		begin_test("register access");
		for (int n = 0; n < 16; n++) begin
			idx = lcg_random() % pixels;
			written.push_back(idx);
			write_pixel(idx, random_pixel());
		end
		foreach (written[n])
			check_pixel(written[n]);
		// control register round trip, enable is only on for a few cycles
		axil_write(display_pkg::CTRL_ADDR, 32'd1, 4'hf, resp);
		check_ctrl(32'd1);
		axil_write(display_pkg::CTRL_ADDR, 32'd0, 4'hf, resp);
		check_ctrl(32'd0);
		// 0x804 aliases pixel 1 in the index bits, must not touch it
		write_pixel(1, 3'b101);
		axil_write(12'h804, 32'h7, 4'hf, resp);
		if (resp !== 2'd2)
			report_error($sformatf("write to 0x804 answered %0d, expected 2", resp));
		check_ctrl(32'd0);
		check_pixel(1);
		axil_read(12'hffc, data, resp);
		if (resp !== 2'd2)
			report_error($sformatf("read of 0xffc answered %0d, expected 2", resp));
		// byte 0 strobe clear leaves the pixel alone
		write_pixel(5, 3'b010);
		axil_write(12'd20, 32'h5, 4'b1110, resp);
		if (resp !== 2'd0)
			report_error($sformatf("strobe-less write answered %0d", resp));
		check_pixel(5);
		end_test();
	endtask

	task automatic test_back_pressure();
		display_pkg::pixel_t pa;
		display_pkg::pixel_t pb;
		logic [1:0] held_resp;
		logic [31:0] held_data;
		begin_test("back-pressure");
		pa = random_pixel();
		pb = ~pa;
		@(negedge clk);
		axil_req.awaddr = 12'(7 * 4);
		axil_req.wdata = {29'd0, pa};
		axil_req.wstrb = 4'hf;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid = 1'b1;
		axil_req.bready = 1'b0;
		while (!axil_rsp.awready)
			@(negedge clk);
		@(negedge clk);
		model[7] = pa;
		// offer a second write while the first response waits
		axil_req.awaddr = 12'(300 * 4);
		axil_req.wdata = {29'd0, pb};
		while (!axil_rsp.bvalid)
			@(negedge clk);
		held_resp = axil_rsp.bresp;
		repeat (6) begin
			@(negedge clk);
			if (!axil_rsp.bvalid || axil_rsp.bresp !== held_resp)
				report_error("write response changed while bready was low");
			if (axil_rsp.awready || axil_rsp.wready)
				report_error("write accepted while a write response was pending");
		end
		axil_req.bready = 1'b1;
		while (!axil_rsp.awready)
			@(negedge clk);
		@(negedge clk);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		model[300] = pb;
		while (!axil_rsp.bvalid)
			@(negedge clk);
		@(negedge clk);
		axil_req.bready = 1'b0;
		// read side, second address offered during the stalled response
		axil_req.araddr = 12'(7 * 4);
		axil_req.arvalid = 1'b1;
		axil_req.rready = 1'b0;
		while (!axil_rsp.arready)
			@(negedge clk);
		@(negedge clk);
		axil_req.araddr = 12'(300 * 4);
		while (!axil_rsp.rvalid)
			@(negedge clk);
		held_data = axil_rsp.rdata;
		held_resp = axil_rsp.rresp;
		if (held_data !== {29'd0, model[7]})
			report_error($sformatf("stalled read returned %h", held_data));
		repeat (6) begin
			@(negedge clk);
			if (!axil_rsp.rvalid || axil_rsp.rdata !== held_data || axil_rsp.rresp !== held_resp)
				report_error("read response changed while rready was low");
			if (axil_rsp.arready)
				report_error("read accepted while a read response was pending");
		end
		axil_req.rready = 1'b1;
		while (!axil_rsp.arready)
			@(negedge clk);
		@(negedge clk);
		axil_req.arvalid = 1'b0;
		while (!axil_rsp.rvalid)
			@(negedge clk);
		if (axil_rsp.rdata !== {29'd0, model[300]})
			report_error($sformatf("second read returned %h", axil_rsp.rdata));
		@(negedge clk);
		axil_req.rready = 1'b0;
		end_test();
	endtask

	task automatic test_row_content();
		logic [1:0] resp;
		begin_test("row content");
		for (int i = 0; i < pixels; i++)
			write_pixel(i, random_pixel());
		oclk_count = 0;
		latch_count = 0;
		expected_row = 0;
		scan_check = 1'b1;
		axil_write(display_pkg::CTRL_ADDR, 32'd1, 4'hf, resp);
		while (latch_count < 3)
			@(negedge clk);
		// the row just latched is lit from the next cycle on
		repeat (2) @(negedge clk);
		if (oe !== 1'b1)
			report_error("oe low while a latched row is shown");
		end_test();
	endtask

	task automatic test_row_order();
		int start;
		begin_test("row order");
		start = latch_count;
		// a full frame plus a few rows past the wrap
		while (latch_count < start + rows + 3)
			@(negedge clk);
		end_test();
	endtask

	task automatic test_disable();
		int seen;
		logic [1:0] resp;
		begin_test("disable");
		axil_write(display_pkg::CTRL_ADDR, 32'd0, 4'hf, resp);
		@(negedge clk);
		@(negedge clk);
		seen = oclk_count;
		repeat (200) begin
			@(negedge clk);
			if (oe !== 1'b0)
				report_error("oe high while scanning is disabled");
		end
		if (oclk_count != seen)
			report_error($sformatf("%0d oclk pulses while disabled", oclk_count - seen));
		// the interrupted row is dropped, the loader starts over at column 0
		oclk_count = 0;
		seen = latch_count;
		axil_write(display_pkg::CTRL_ADDR, 32'd1, 4'hf, resp);
		while (latch_count < seen + 2)
			@(negedge clk);
		end_test();
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		axil_req = '0;
		lcg_state = 32'h21df;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cycles = 0;
		oclk_count = 0;
		latch_count = 0;
		expected_row = 0;
		scan_check = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_reset_state();
		test_register_access();
		test_back_pressure();
		test_row_content();
		test_row_order();
		test_disable();

		errors = errors + dut_i.scan_i.assert_i.failures;
		$display("%0d tests run, %0d passed, %0d failed, %0d errors, %0d assertion failures",
			tests_run, tests_run - tests_failed, tests_failed, errors,
			dut_i.scan_i.assert_i.failures);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end
endmodule

//--- verilog.f
hw/display_pkg.sv
hw/display_axil_slave.sv
hw/display_frame_buffer.sv
hw/display_driver_row_loader.sv
hw/display_pixel_pipe.sv
hw/display_scan_controller.sv
hw/display_top.sv
tb/display_assert.sv
tb/display_tb.sv
